// ==== dv/queue_store_tb.sv ====
/*
  Testbench for the shared-memory queue store.
  Producer and consumer models follow the credit rules; concurrent assertions
  compare pops with scoreboard heads and check credits and status flags.
  Stimulus comes from an LCG with a fixed seed, so runs repeat exactly.
  Tests assume QS_CHANNELS >= 2; the flush test uses the last channel.
*/
`timescale 1ns/1ps
`include "queue_store_config.svh"

module queue_store_tb import queue_store_pkg::*; ();

  localparam int CH         = `QS_CHANNELS;
  localparam int STAGE      = `QS_STAGE_DEPTH;
  localparam int WAIT_LIMIT = 300;

  logic            clock;
  logic            resetn;
  queue_entry_t    push            [CH];
  logic [CH-1:0]   push_credit;
  logic [CH-1:0]   pop_credit;
  queue_entry_t    pop             [CH];
  logic [CH-1:0]   flush;
  level_t          lower_threshold [CH];
  level_t          upper_threshold [CH];
  channel_status_t status          [CH];

  // Scoreboard and credit models
  data_t         expected [CH][$];
  int            credits  [CH];
  int            sent     [CH];
  int            seen     [CH];
  // Copies seen by the assertions, one cycle behind the models
  int            credit_view [CH];
  int            sent_view   [CH];
  int            seen_view   [CH];
  logic [CH-1:0] head_valid;
  data_t         head_data   [CH];
  logic [CH-1:0] no_credit_push;
  logic [CH-1:0] error_expected;
  logic [5:0]    flags_expected [CH];
  logic [5:0]    flags_actual   [CH];
  // Mid-cycle samples of full and push_credit
  logic [CH-1:0] full_seen;
  logic [CH-1:0] credit_seen;

  logic [31:0]   lcg_state;
  string         test_name;
  int            errors;
  int            errors_at_start;
  int            tests;
  bit            timed_out;

  queue_store_top u_dut (
    .clock           (clock),
    .resetn          (resetn),
    .push            (push),
    .push_credit     (push_credit),
    .pop_credit      (pop_credit),
    .pop             (pop),
    .flush           (flush),
    .lower_threshold (lower_threshold),
    .upper_threshold (upper_threshold),
    .status          (status)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [CH-1:0] random_mask();
    return CH'(next_random() >> 16);
  endfunction

  function automatic logic [CH-1:0] one_channel(input int c);
    return CH'(1) << c;
  endfunction

  // Flag order: empty, full, almost empty, almost full, lower, upper
  function automatic logic [5:0] expected_flags(input level_t level, input level_t lower,
                                                input level_t upper);
    return {level == level_t'(0), level == level_t'(`QS_DEPTH), level == level_t'(1),
            level == level_t'(`QS_DEPTH - 1), level <= lower, level >= upper};
  endfunction

  task automatic value_error(input string check, input int expected_value, input int actual);
    $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, check,
             expected_value, actual);
    errors++;
  endtask

  task automatic plain_error(input string message);
    $display("%s: %s", test_name, message);
    errors++;
  endtask

  task automatic note_timeout(input string what);
    $display("%s: timed out while %s", test_name, what);
    errors++;
    timed_out = 1'b1;
  endtask

  // Sample outputs at the falling edge, drive inputs on the rising edge
  task automatic drive_cycle(input logic [CH-1:0] push_en, input logic [CH-1:0] illegal_en,
                             input logic [CH-1:0] credit_en, input logic [CH-1:0] flush_en);
    queue_entry_t entry;
    logic [31:0]  r;
    int           outstanding;
    @(negedge clock);
    for (int c = 0; c < CH; c++) begin
      full_seen[c]   = status[c].full;
      credit_seen[c] = push_credit[c];
      if (push_credit[c]) begin
        credits[c]++;
      end
      if (pop[c].valid) begin
        seen[c]++;
        if (expected[c].size() != 0) begin
          void'(expected[c].pop_front());
        end
      end
    end
    @(posedge clock);
    for (int c = 0; c < CH; c++) begin
      r = next_random();
      entry.valid = 1'b0;
      entry.data  = data_t'(r[31:16]);
      if (push_en[c] && credits[c] > 0) begin
        entry.valid = 1'b1;
        credits[c]--;
        expected[c].push_back(entry.data);
      end else if (illegal_en[c]) begin
        // Dropped by the DUT, so never enters the scoreboard
        entry.valid = 1'b1;
      end
      push[c]           <= entry;
      error_expected[c] <= no_credit_push[c];
      no_credit_push[c] <= illegal_en[c];
      // Credits only for entries still owed, and within the holding limit
      outstanding   = sent[c] - seen[c];
      pop_credit[c] <= 1'b0;
      if (credit_en[c] && outstanding < `QS_POP_CREDITS
          && outstanding < expected[c].size()) begin
        pop_credit[c] <= 1'b1;
        sent[c]++;
      end
      if (flush_en[c]) begin
        expected[c].delete();
      end
      flush[c]       <= flush_en[c];
      head_valid[c]  <= expected[c].size() != 0;
      head_data[c]   <= (expected[c].size() != 0) ? expected[c][0] : '0;
      credit_view[c] <= credits[c];
      sent_view[c]   <= sent[c];
      seen_view[c]   <= seen[c];
    end
  endtask

  function automatic bit all_settled();
    for (int c = 0; c < CH; c++) begin
      if (expected[c].size() != 0 || credits[c] != STAGE || sent[c] != seen[c]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic bit credits_home();
    for (int c = 0; c < CH; c++) begin
      if (credits[c] != STAGE) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drain_all(input string what);
    int count;
    count = 0;
    while (!all_settled() && !timed_out) begin
      drive_cycle('0, '0, '1, '0);
      count++;
      if (count > WAIT_LIMIT) begin
        note_timeout(what);
      end
    end
  endtask

  // Consumer credits withheld, so only the writes finish
  task automatic wait_credits_back(input string what);
    int count;
    count = 0;
    while (!credits_home() && !timed_out) begin
      drive_cycle('0, '0, '0, '0);
      count++;
      if (count > WAIT_LIMIT) begin
        note_timeout(what);
      end
    end
  endtask

  // Push until full is seen, pulses have stopped and the producer is out of credits
  task automatic fill_channel(input int c);
    int count;
    int quiet;
    count = 0;
    quiet = 0;
    while (!(quiet >= 4 && credits[c] == 0) && !timed_out) begin
      drive_cycle(one_channel(c), '0, '0, '0);
      if (full_seen[c] && !credit_seen[c]) begin
        quiet++;
      end else begin
        quiet = 0;
      end
      count++;
      if (count > WAIT_LIMIT) begin
        note_timeout("filling a channel until full");
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    for (int c = 0; c < CH; c++) begin
      lower_threshold[c] <= level_t'(next_random() % (`QS_DEPTH + 1));
      upper_threshold[c] <= level_t'(next_random() % (`QS_DEPTH + 1));
    end
  endtask

  task automatic finish_test();
    $display("%-18s finished, %0d failed checks", test_name, errors - errors_at_start);
    tests++;
  endtask

  for (genvar c = 0; c < CH; c++) begin : g_check
    assign flags_expected[c] = expected_flags(status[c].level, lower_threshold[c],
                                              upper_threshold[c]);
    assign flags_actual[c]   = {status[c].empty, status[c].full, status[c].almost_empty,
                                status[c].almost_full, status[c].lower_status,
                                status[c].upper_status};

    a_pop_owed: assert property (@(posedge clock) disable iff (!resetn)
      pop[c].valid |-> head_valid[c])
      else plain_error("a pop arrived with no entry outstanding");

    // Per-channel order
    a_pop_order: assert property (@(posedge clock) disable iff (!resetn)
      pop[c].valid && head_valid[c] |-> pop[c].data == head_data[c])
      else value_error("pop data", int'($sampled(head_data[c])), int'($sampled(pop[c].data)));

    a_producer_credits: assert property (@(posedge clock) disable iff (!resetn)
      credit_view[c] >= 0 && credit_view[c] <= STAGE)
      else value_error("producer credits", STAGE, $sampled(credit_view[c]));

    a_pop_within_credits: assert property (@(posedge clock) disable iff (!resetn)
      seen_view[c] <= sent_view[c])
      else value_error("pops against credits", $sampled(sent_view[c]), $sampled(seen_view[c]));

    a_level_space: assert property (@(posedge clock) disable iff (!resetn)
      int'(status[c].level) + int'(status[c].space) == `QS_DEPTH)
      else value_error("level plus space", `QS_DEPTH,
                       int'($sampled(status[c].level)) + int'($sampled(status[c].space)));

    a_status_flags: assert property (@(posedge clock) disable iff (!resetn)
      flags_actual[c] == flags_expected[c])
      else value_error("status flags", int'($sampled(flags_expected[c])),
                       int'($sampled(flags_actual[c])));

    a_flush_empties: assert property (@(posedge clock) disable iff (!resetn)
      $past(flush[c]) |-> status[c].level == level_t'(0))
      else value_error("level after flush", 0, int'($sampled(status[c].level)));

    // Pulses exactly one cycle after an uncredited push, and never otherwise
    a_credit_error: assert property (@(posedge clock) disable iff (!resetn)
      status[c].credit_error == error_expected[c])
      else value_error("credit_error", int'($sampled(error_expected[c])),
                       int'($sampled(status[c].credit_error)));
  end

  initial begin
    int count;
    lcg_state       = 32'd62924;
    errors          = 0;
    errors_at_start = 0;
    tests           = 0;
    timed_out       = 1'b0;
    test_name       = "reset";
    resetn          = 1'b0;
    pop_credit      = '0;
    flush           = '0;
    no_credit_push  = '0;
    error_expected  = '0;
    head_valid      = '0;
    full_seen       = '0;
    credit_seen     = '0;
    for (int c = 0; c < CH; c++) begin
      push[c]            = '0;
      lower_threshold[c] = '0;
      upper_threshold[c] = level_t'(`QS_DEPTH);
      credits[c]         = STAGE;
      sent[c]            = 0;
      seen[c]            = 0;
      credit_view[c]     = STAGE;
      sent_view[c]       = 0;
      seen_view[c]       = 0;
      head_data[c]       = '0;
    end
    repeat (10) @(posedge clock);
    resetn <= 1'b1;

    start_test("random_traffic");
    for (int i = 0; i < 400; i++) begin
      drive_cycle(random_mask(), '0, random_mask(), '0);
    end
    drain_all("draining random traffic");
    finish_test();

    start_test("simultaneous_push");
    for (int i = 0; i < 40; i++) begin
      drive_cycle('1, '0, '1, '0);
    end
    drain_all("draining simultaneous pushes");
    finish_test();

    start_test("fill_and_drain");
    fill_channel(0);
    drain_all("draining a full channel");
    finish_test();

    // Full queue and full staging, so an uncredited push is refused
    start_test("credit_error");
    fill_channel(CH - 1);
    drive_cycle('0, one_channel(CH - 1), '0, '0);
    repeat (3) drive_cycle('0, '0, '0, '0);
    drain_all("draining after a refused push");
    finish_test();

    start_test("flush");
    count = 0;
    while (expected[CH - 1].size() < 3 && !timed_out) begin
      drive_cycle(one_channel(CH - 1), '0, '0, '0);
      count++;
      if (count > WAIT_LIMIT) begin
        note_timeout("pushing ahead of a flush");
      end
    end
    wait_credits_back("waiting for staged entries before a flush");
    drive_cycle('0, '0, '0, one_channel(CH - 1));
    repeat (3) drive_cycle('0, '0, '0, '0);
    drive_cycle(one_channel(CH - 1), '0, '0, '0);
    drain_all("draining after a flush");
    finish_test();

    $display("Summary: %0d tests run, %0d checks failed", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/queue_channel_controller.sv ====
/*
  Queue controller for one channel of the shared memory.
  Pushes land in a small staging buffer and are written when the write
  arbiter grants; each write returns one producer credit.
  Reads are requested only against consumer credits held, so pop never sees
  an empty queue. Flush drops stored entries, not staged ones.
*/
`timescale 1ns/1ps
`include "queue_store_config.svh"

module queue_channel_controller import queue_store_pkg::*; #(
  parameter int unsigned CHANNEL_ID = 0
) (
  input  logic            clock,
  input  logic            resetn,
  input  queue_entry_t    push,
  output logic            push_credit,
  input  logic            pop_credit,
  output queue_entry_t    pop,
  input  logic            flush,
  input  level_t          lower_threshold,
  input  level_t          upper_threshold,
  output channel_status_t status,
  output logic            write_request,
  output write_req_t      write_payload,
  input  logic            write_grant,
  output logic            read_request,
  output read_req_t       read_payload,
  input  logic            read_grant,
  input  read_resp_t      read_response
);

  localparam int STAGE_BITS  = $clog2(`QS_STAGE_DEPTH);
  localparam int COUNT_BITS  = $clog2(`QS_STAGE_DEPTH + 1);
  localparam int CREDIT_BITS = $clog2(`QS_POP_CREDITS + 1);

  // Staging buffer, a tiny circular FIFO
  data_t                 stage_data [`QS_STAGE_DEPTH];
  logic [STAGE_BITS-1:0] stage_head;
  logic [STAGE_BITS-1:0] stage_tail;
  logic [COUNT_BITS-1:0] stage_count;
  logic                  stage_full;
  logic                  stage_accept;

  // Lap-bit pointers into this channel's region
  level_t write_pointer;
  level_t read_pointer;
  level_t level;
  logic   empty;
  logic   full;

  logic [CREDIT_BITS-1:0] pop_credits;
  logic                   credit_error;

  function automatic logic [STAGE_BITS-1:0] next_slot(input logic [STAGE_BITS-1:0] slot);
    if (slot == STAGE_BITS'(`QS_STAGE_DEPTH - 1)) begin
      return '0;
    end
    return slot + 1'b1;
  endfunction

  assign stage_full   = stage_count == COUNT_BITS'(`QS_STAGE_DEPTH);
  // Push without a free slot means the producer had no credit
  assign stage_accept = push.valid && !stage_full;

  // Payload storage
  always_ff @(posedge clock) begin
    if (stage_accept) begin
      stage_data[stage_tail] <= push.data;
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      stage_head    <= '0;
      stage_tail    <= '0;
      stage_count   <= '0;
      write_pointer <= '0;
      read_pointer  <= '0;
      pop_credits   <= '0;
      push_credit   <= 1'b0;
      credit_error  <= 1'b0;
    end else begin
      if (stage_accept) begin
        stage_tail <= next_slot(stage_tail);
      end
      // Granted write leaves staging and frees a producer slot
      if (write_grant) begin
        stage_head    <= next_slot(stage_head);
        write_pointer <= write_pointer + 1'b1;
      end
      case ({stage_accept, write_grant})
        2'b10:   stage_count <= stage_count + 1'b1;
        2'b01:   stage_count <= stage_count - 1'b1;
        default: stage_count <= stage_count;
      endcase
      // Flush discards stored entries; a write in the same cycle survives
      if (flush) begin
        read_pointer <= write_pointer;
      end else if (read_grant) begin
        read_pointer <= read_pointer + 1'b1;
      end
      // Consumer credit bookkeeping
      case ({pop_credit, read_grant})
        2'b10:   pop_credits <= pop_credits + 1'b1;
        2'b01:   pop_credits <= pop_credits - 1'b1;
        default: pop_credits <= pop_credits;
      endcase
      push_credit  <= write_grant;
      credit_error <= push.valid && stage_full;
    end
  end

  // Power-of-two depth, so the lap bit wraps for free
  assign level = write_pointer - read_pointer;
  // Same address, lap bits tell empty from full
  assign empty = write_pointer == read_pointer;
  assign full  = (write_pointer[`QS_ADDR_BITS-1:0] == read_pointer[`QS_ADDR_BITS-1:0])
              && (write_pointer[`QS_ADDR_BITS] != read_pointer[`QS_ADDR_BITS]);

  // Memory requests
  assign write_request         = (stage_count != '0) && !full;
  assign write_payload.channel = channel_t'(CHANNEL_ID);
  assign write_payload.address = write_pointer[`QS_ADDR_BITS-1:0];
  assign write_payload.data    = stage_data[stage_head];

  assign read_request         = !empty && (pop_credits != '0) && !flush;
  assign read_payload.channel = channel_t'(CHANNEL_ID);
  assign read_payload.address = read_pointer[`QS_ADDR_BITS-1:0];

  // Only the response tagged with this channel becomes a pop
  assign pop.valid = read_response.valid && (read_response.channel == channel_t'(CHANNEL_ID));
  assign pop.data  = read_response.data;

  assign status.level        = level;
  assign status.space        = level_t'(`QS_DEPTH) - level;
  assign status.empty        = empty;
  assign status.full         = full;
  assign status.almost_empty = level == level_t'(1);
  assign status.almost_full  = level == level_t'(`QS_DEPTH - 1);
  assign status.lower_status = level <= lower_threshold;
  assign status.upper_status = level >= upper_threshold;
  assign status.credit_error = credit_error;

  // Ring pointers meet only when staging is empty or full
  a_stage_bound: assert property (@(posedge clock) disable iff (!resetn)
    (stage_head == stage_tail) == (stage_count == '0 || stage_full));

  // Consumer must not grant more than the controller can hold
  a_pop_credit_bound: assert property (@(posedge clock) disable iff (!resetn)
    pop_credits <= CREDIT_BITS'(`QS_POP_CREDITS));

  // Every read grant comes back through the shared memory one cycle later
  a_read_returns: assert property (@(posedge clock) disable iff (!resetn)
    read_grant |=> pop.valid);

endmodule

// ==== logic/queue_memory.sv ====
/*
  Shared simple dual-port storage for all channel queues.
  Word address is the channel above the local address. Read data is
  registered and comes back one cycle after the read grant, tagged with the
  requesting channel. Reading and writing one word in the same cycle is not
  expected: only written entries are ever read.
*/
`timescale 1ns/1ps
`include "queue_store_config.svh"

module queue_memory import queue_store_pkg::*; (
  input  logic       clock,
  input  logic       resetn,
  input  logic       write_valid,
  input  write_req_t write,
  input  logic       read_valid,
  input  read_req_t  read,
  output read_resp_t read_response
);

  localparam int WORDS = `QS_CHANNELS * `QS_DEPTH;

  data_t    storage [WORDS];
  logic     response_valid;
  channel_t response_channel;
  data_t    response_data;

  always_ff @(posedge clock) begin
    if (write_valid) begin
      storage[{write.channel, write.address}] <= write.data;
    end
    if (read_valid) begin
      response_channel <= read.channel;
      response_data    <= storage[{read.channel, read.address}];
    end
  end

  // Valid tag is the only control state here
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      response_valid <= 1'b0;
    end else begin
      response_valid <= read_valid;
    end
  end

  assign read_response.valid   = response_valid;
  assign read_response.channel = response_channel;
  assign read_response.data    = response_data;

endmodule

// ==== logic/queue_memory_arbiter.sv ====
/*
  Round-robin arbiter for one shared memory port.
  The payload type is a parameter so the same block serves the write and the
  read port. Grant is combinational; the last winner has lowest priority on
  the next cycle, so a held request waits at most QS_CHANNELS-1 cycles.
*/
`timescale 1ns/1ps
`include "queue_store_config.svh"

module queue_memory_arbiter import queue_store_pkg::*; #(
  parameter type payload_t = write_req_t
) (
  input  logic                    clock,
  input  logic                    resetn,
  input  logic [`QS_CHANNELS-1:0] request,
  input  payload_t                payload [`QS_CHANNELS],
  output logic [`QS_CHANNELS-1:0] grant,
  output payload_t                granted,
  output logic                    granted_valid
);

  channel_t last_winner;
  channel_t winner;

  // Search starts just after the previous winner
  always_comb begin
    int unsigned candidate;
    candidate     = 0;
    grant         = '0;
    winner        = last_winner;
    granted_valid = 1'b0;
    for (int offset = 1; offset <= `QS_CHANNELS; offset++) begin
      candidate = (int'(last_winner) + offset) % `QS_CHANNELS;
      if (!granted_valid && request[candidate]) begin
        granted_valid    = 1'b1;
        winner           = channel_t'(candidate);
        grant[candidate] = 1'b1;
      end
    end
  end

  // Mux of the winning payload
  assign granted = payload[winner];

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      // Channel 0 gets first turn
      last_winner <= channel_t'(`QS_CHANNELS - 1);
    end else if (granted_valid) begin
      last_winner <= winner;
    end
  end

  a_grant_onehot: assert property (@(posedge clock) disable iff (!resetn)
    $onehot0(grant));

  a_grant_requested: assert property (@(posedge clock) disable iff (!resetn)
    (grant & ~request) == '0);

endmodule

// ==== logic/queue_store_config.svh ====
/*
  Build-time sizing for the shared-memory queue store.
  QS_DEPTH must be a power of two: a channel's region is addressed by the
  channel number placed above the local address, and the level is the plain
  difference of two lap-bit pointers.
  QS_CHANNELS and QS_STAGE_DEPTH are assumed to be at least 2.
*/
`ifndef QUEUE_STORE_CONFIG_SVH
`define QUEUE_STORE_CONFIG_SVH

// Channel queues sharing the memory
`define QS_CHANNELS 2
// Entries per channel, power of two
`define QS_DEPTH 8
// Data bits per entry
`define QS_WIDTH 16
// Staging slots per channel, also the producer's credits after reset
`define QS_STAGE_DEPTH 2
// Most consumer credits one controller may hold
`define QS_POP_CREDITS 4

// Derived widths
`define QS_CHANNEL_BITS $clog2(`QS_CHANNELS)
`define QS_ADDR_BITS $clog2(`QS_DEPTH)

`endif

// ==== logic/queue_store_pkg.sv ====
/*
  Shared types of the queue store.
  Widths come from the config header; a level is one bit wider than a local
  address so that a completely full queue can be represented.
*/
`include "queue_store_config.svh"

package queue_store_pkg;

  typedef logic [`QS_CHANNEL_BITS-1:0] channel_t;
  typedef logic [`QS_ADDR_BITS-1:0]    address_t;
  // Lap bit on top of the local address
  typedef logic [`QS_ADDR_BITS:0]      level_t;
  typedef logic [`QS_WIDTH-1:0]        data_t;

  // Push and pop word
  typedef struct packed {
    logic  valid;
    data_t data;
  } queue_entry_t;

  // Shared write port request
  typedef struct packed {
    channel_t channel;
    address_t address;
    data_t    data;
  } write_req_t;

  // Shared read port request
  typedef struct packed {
    channel_t channel;
    address_t address;
  } read_req_t;

  // Registered read data, tagged with its channel
  typedef struct packed {
    logic     valid;
    channel_t channel;
    data_t    data;
  } read_resp_t;

  typedef struct packed {
    level_t level;
    level_t space;
    logic   empty;
    logic   full;
    logic   almost_empty;
    logic   almost_full;
    logic   lower_status;
    logic   upper_status;
    logic   credit_error;
  } channel_status_t;

endpackage

// ==== logic/queue_store_top.sv ====
/*
  Multi-channel queue store on one shared memory.
  Producer side: QS_STAGE_DEPTH credits per channel after reset, one back
  per push_credit pulse. Consumer side: pulse pop_credit per entry it can
  take, never more than QS_POP_CREDITS outstanding.
  A push without credit is dropped and flagged in status.credit_error.
*/
`timescale 1ns/1ps
`include "queue_store_config.svh"

module queue_store_top import queue_store_pkg::*; (
  input  logic                    clock,
  input  logic                    resetn,
  input  queue_entry_t            push            [`QS_CHANNELS],
  output logic [`QS_CHANNELS-1:0] push_credit,
  input  logic [`QS_CHANNELS-1:0] pop_credit,
  output queue_entry_t            pop             [`QS_CHANNELS],
  input  logic [`QS_CHANNELS-1:0] flush,
  input  level_t                  lower_threshold [`QS_CHANNELS],
  input  level_t                  upper_threshold [`QS_CHANNELS],
  output channel_status_t         status          [`QS_CHANNELS]
);

  // Write port
  logic [`QS_CHANNELS-1:0] write_request;
  logic [`QS_CHANNELS-1:0] write_grant;
  write_req_t              write_payload [`QS_CHANNELS];
  write_req_t              write_granted;
  logic                    write_valid;

  // Read port
  logic [`QS_CHANNELS-1:0] read_request;
  logic [`QS_CHANNELS-1:0] read_grant;
  read_req_t               read_payload [`QS_CHANNELS];
  read_req_t               read_granted;
  logic                    read_valid;

  // Broadcast to every controller
  read_resp_t read_response;

  for (genvar c = 0; c < `QS_CHANNELS; c++) begin : g_channel
    queue_channel_controller #(
      .CHANNEL_ID (c)
    ) u_controller (
      .clock           (clock),
      .resetn          (resetn),
      .push            (push[c]),
      .push_credit     (push_credit[c]),
      .pop_credit      (pop_credit[c]),
      .pop             (pop[c]),
      .flush           (flush[c]),
      .lower_threshold (lower_threshold[c]),
      .upper_threshold (upper_threshold[c]),
      .status          (status[c]),
      .write_request   (write_request[c]),
      .write_payload   (write_payload[c]),
      .write_grant     (write_grant[c]),
      .read_request    (read_request[c]),
      .read_payload    (read_payload[c]),
      .read_grant      (read_grant[c]),
      .read_response   (read_response)
    );
  end

  queue_memory_arbiter #(
    .payload_t (write_req_t)
  ) u_write_arbiter (
    .clock         (clock),
    .resetn        (resetn),
    .request       (write_request),
    .payload       (write_payload),
    .grant         (write_grant),
    .granted       (write_granted),
    .granted_valid (write_valid)
  );

  queue_memory_arbiter #(
    .payload_t (read_req_t)
  ) u_read_arbiter (
    .clock         (clock),
    .resetn        (resetn),
    .request       (read_request),
    .payload       (read_payload),
    .grant         (read_grant),
    .granted       (read_granted),
    .granted_valid (read_valid)
  );

  queue_memory u_memory (
    .clock         (clock),
    .resetn        (resetn),
    .write_valid   (write_valid),
    .write         (write_granted),
    .read_valid    (read_valid),
    .read          (read_granted),
    .read_response (read_response)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the queue store testbench with Verilator and run it.
# The fail message in sim.log marks a failed run; a log without the pass
# message (a crash or an RTL assertion stop) counts as failed too.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module queue_store_tb -f sources.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vqueue_store_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation passed"

// ==== sources.f ====
+incdir+logic
logic/queue_store_pkg.sv
logic/queue_channel_controller.sv
logic/queue_memory_arbiter.sv
logic/queue_memory.sv
logic/queue_store_top.sv
dv/queue_store_tb.sv
